// ==== verilog/capture_pkg.sv ====
package capture_pkg;

   // bus and sample widths
   localparam int DATA_W     = 8;
   localparam int ADDR_W     = 8;

   // shared sample buffer
   localparam int FIFO_DEPTH = 16;
   localparam int PTR_W      = 4;   // log2 of FIFO_DEPTH
   localparam int CNT_W      = 5;   // holds 0..FIFO_DEPTH

   // error LED flash counter, top bit toggles every 8 cycles
   localparam int FLASH_W    = 4;

   localparam logic [DATA_W-1:0] CAPTURE_ID = 8'hC7;

   // REG_CTRL bits
   localparam int CTRL_ARM    = 0;
   localparam int CTRL_SRC_LA = 1;   // 0 trace, 1 logic analyzer

   // REG_CLEAR bits, self clearing
   localparam int CLR_FLUSH   = 0;
   localparam int CLR_ERRORS  = 1;

   // REG_STATUS bits, count sits in the low bits
   localparam int ST_ERR      = 7;
   localparam int ST_FULL     = 6;
   localparam int ST_EMPTY    = 5;

   typedef enum logic [ADDR_W-1:0] {
      REG_ID        = 8'h00,   // read only
      REG_CTRL      = 8'h01,   // read/write
      REG_CLEAR     = 8'h02,   // write only
      REG_STATUS    = 8'h03,   // read only
      REG_FIFO_DATA = 8'h04    // read pops the buffer
   } reg_addr_t;

   typedef enum logic [1:0] {
      IDLE,
      WR_HOLD,
      RD_WAIT,
      RD_DRIVE
   } bus_state_t;

endpackage

// ==== verilog/usb_reg_bus.sv ====
`timescale 1ns/10ps

module usb_reg_bus (
   input  logic                            clk_usb_buf,
   input  logic                            rst_n_i,
   input  logic                            usb_cen_n_i,
   input  logic                            usb_wrn_n_i,
   input  logic                            usb_rdn_n_i,
   input  logic [capture_pkg::ADDR_W-1:0]  usb_addr_i,
   input  logic [capture_pkg::DATA_W-1:0]  usb_data_i,
   output logic [capture_pkg::DATA_W-1:0]  usb_data_o,
   output logic                            usb_data_oe_o,
   output logic [capture_pkg::ADDR_W-1:0]  reg_address_o,
   output logic [capture_pkg::DATA_W-1:0]  write_data_o,
   output logic                            reg_write_o,
   output logic                            reg_read_o,
   input  logic [capture_pkg::DATA_W-1:0]  reg_rdata_i
);

   capture_pkg::bus_state_t state_q;
   capture_pkg::bus_state_t state_d;
   logic                    idle;
   logic                    wr_go;
   logic                    rd_go;

   assign idle  = (state_q == capture_pkg::IDLE);
   assign wr_go = idle & ~usb_cen_n_i & ~usb_wrn_n_i;
   assign rd_go = idle & ~usb_cen_n_i & ~usb_rdn_n_i & usb_wrn_n_i;   // write wins

   always_comb begin
      state_d = state_q;
      case (state_q)
         capture_pkg::IDLE: begin
            if (wr_go) begin
               state_d = capture_pkg::WR_HOLD;
            end else if (rd_go) begin
               state_d = capture_pkg::RD_WAIT;
            end
         end
         capture_pkg::WR_HOLD: begin
            if (usb_wrn_n_i) begin   // wait for strobe release
               state_d = capture_pkg::IDLE;
            end
         end
         capture_pkg::RD_WAIT: begin
            state_d = capture_pkg::RD_DRIVE;   // regs latch read data here
         end
         capture_pkg::RD_DRIVE: begin
            if (usb_rdn_n_i) begin
               state_d = capture_pkg::IDLE;
            end
         end
         default: begin
            state_d = capture_pkg::IDLE;
         end
      endcase
   end

   always_ff @(posedge clk_usb_buf or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q     <= capture_pkg::IDLE;
         reg_write_o <= 1'b0;
         reg_read_o  <= 1'b0;
      end else begin
         state_q     <= state_d;
         reg_write_o <= wr_go;   // one pulse per access
         reg_read_o  <= rd_go;
      end
   end

   // host holds address and data while the strobe is low
   always_ff @(posedge clk_usb_buf) begin
      if (wr_go || rd_go) begin
         reg_address_o <= usb_addr_i;
      end
      if (wr_go) begin
         write_data_o <= usb_data_i;
      end
   end

   assign usb_data_oe_o = (state_q == capture_pkg::RD_DRIVE);
   assign usb_data_o    = reg_rdata_i;   // already registered in the regs

   // each pulse must match the state the fsm took, so read and write never overlap
   a_wr_pulse: assert property (@(posedge clk_usb_buf) disable iff (!rst_n_i)
      reg_write_o |-> state_q == capture_pkg::WR_HOLD);

   a_rd_pulse: assert property (@(posedge clk_usb_buf) disable iff (!rst_n_i)
      reg_read_o |-> state_q == capture_pkg::RD_WAIT);

endmodule

// ==== verilog/capture_regs.sv ====
`timescale 1ns/10ps

module capture_regs (
   input  logic                            clk_usb_buf,
   input  logic                            rst_n_i,
   input  logic [capture_pkg::ADDR_W-1:0]  reg_address_i,
   input  logic [capture_pkg::DATA_W-1:0]  write_data_i,
   input  logic                            reg_write_i,
   input  logic                            reg_read_i,
   output logic [capture_pkg::DATA_W-1:0]  reg_rdata_o,
   output logic                            arm_o,
   output logic                            src_la_o,
   output logic                            fifo_pop_o,
   output logic                            fifo_flush_o,
   output logic                            clear_errors_o,
   input  logic [capture_pkg::DATA_W-1:0]  fifo_rdata_i,
   input  logic [capture_pkg::CNT_W-1:0]   fifo_count_i,
   input  logic                            fifo_empty_i,
   input  logic                            fifo_full_i,
   input  logic                            fifo_error_i
);

   logic                           fifo_rd_q;   // last read was FIFO_DATA
   logic [capture_pkg::DATA_W-1:0] rdata_q;
   logic [capture_pkg::DATA_W-1:0] rd_mux;
   logic [capture_pkg::DATA_W-1:0] ctrl_w;
   logic [capture_pkg::DATA_W-1:0] status_w;
   logic                           wr_ctrl;
   logic                           wr_clear;
   logic                           rd_fifo;

   assign wr_ctrl  = reg_write_i && (reg_address_i == capture_pkg::REG_CTRL);
   assign wr_clear = reg_write_i && (reg_address_i == capture_pkg::REG_CLEAR);
   assign rd_fifo  = reg_read_i && (reg_address_i == capture_pkg::REG_FIFO_DATA);

   assign fifo_pop_o = rd_fifo;   // head lands at the same edge as rdata_q

   always_ff @(posedge clk_usb_buf or negedge rst_n_i) begin
      if (!rst_n_i) begin
         arm_o          <= 1'b0;
         src_la_o       <= 1'b0;
         fifo_flush_o   <= 1'b0;
         clear_errors_o <= 1'b0;
         fifo_rd_q      <= 1'b0;
      end else begin
         if (wr_ctrl) begin
            arm_o    <= write_data_i[capture_pkg::CTRL_ARM];
            src_la_o <= write_data_i[capture_pkg::CTRL_SRC_LA];
         end
         fifo_flush_o   <= wr_clear & write_data_i[capture_pkg::CLR_FLUSH];
         clear_errors_o <= wr_clear & write_data_i[capture_pkg::CLR_ERRORS];
         if (reg_read_i) begin
            fifo_rd_q <= rd_fifo;
         end
      end
   end

   always_comb begin
      ctrl_w                           = '0;
      ctrl_w[capture_pkg::CTRL_ARM]    = arm_o;
      ctrl_w[capture_pkg::CTRL_SRC_LA] = src_la_o;
   end

   always_comb begin
      status_w                          = '0;
      status_w[capture_pkg::ST_ERR]     = fifo_error_i;
      status_w[capture_pkg::ST_FULL]    = fifo_full_i;
      status_w[capture_pkg::ST_EMPTY]   = fifo_empty_i;
      status_w[capture_pkg::CNT_W-1:0]  = fifo_count_i;
   end

   always_comb begin
      case (reg_address_i)
         capture_pkg::REG_ID:     rd_mux = capture_pkg::CAPTURE_ID;
         capture_pkg::REG_CTRL:   rd_mux = ctrl_w;
         capture_pkg::REG_STATUS: rd_mux = status_w;
         default:                 rd_mux = '0;   // unused and write-only
      endcase
   end

   always_ff @(posedge clk_usb_buf) begin
      if (reg_read_i) begin
         rdata_q <= rd_mux;
      end
   end

   assign reg_rdata_o = fifo_rd_q ? fifo_rdata_i : rdata_q;

endmodule

// ==== verilog/capture_fifo.sv ====
`timescale 1ns/10ps

module capture_fifo (
   input  logic                            clk_usb_buf,
   input  logic                            rst_n_i,
   input  logic                            arm_i,
   input  logic                            src_la_i,
   input  logic                            trace_valid_i,
   input  logic [capture_pkg::DATA_W-1:0]  trace_data_i,
   output logic                            trace_ready_o,
   input  logic                            la_valid_i,
   input  logic [capture_pkg::DATA_W-1:0]  la_data_i,
   output logic                            la_ready_o,
   input  logic                            pop_i,
   input  logic                            flush_i,
   input  logic                            clear_errors_i,
   output logic [capture_pkg::DATA_W-1:0]  rdata_o,
   output logic [capture_pkg::CNT_W-1:0]   count_o,
   output logic                            empty_o,
   output logic                            full_o,
   output logic                            error_o
);

   logic [capture_pkg::DATA_W-1:0] mem [capture_pkg::FIFO_DEPTH];
   logic [capture_pkg::PTR_W-1:0]  wr_ptr_q;
   logic [capture_pkg::PTR_W-1:0]  rd_ptr_q;
   logic [capture_pkg::CNT_W-1:0]  count_q;
   logic [capture_pkg::DATA_W-1:0] push_data;
   logic                           push;
   logic                           pop_ok;

   assign full_o  = (count_q == capture_pkg::CNT_W'(capture_pkg::FIFO_DEPTH));
   assign empty_o = (count_q == '0);
   assign count_o = count_q;

   // only the selected source sees ready
   assign trace_ready_o = arm_i & ~src_la_i & ~full_o;
   assign la_ready_o    = arm_i & src_la_i & ~full_o;

   assign push      = src_la_i ? (la_valid_i & la_ready_o) : (trace_valid_i & trace_ready_o);
   assign push_data = src_la_i ? la_data_i : trace_data_i;
   assign pop_ok    = pop_i & ~empty_o;

   always_ff @(posedge clk_usb_buf or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
         error_o  <= 1'b0;
      end else begin
         if (flush_i) begin   // flush beats push and pop
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
         end else begin
            if (push) begin
               wr_ptr_q <= wr_ptr_q + 1'b1;   // wraps at depth
            end
            if (pop_ok) begin
               rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({push, pop_ok})
               2'b10:   count_q <= count_q + 1'b1;
               2'b01:   count_q <= count_q - 1'b1;
               default: count_q <= count_q;
            endcase
         end
         if (pop_i && empty_o) begin
            error_o <= 1'b1;   // sticky underflow
         end else if (clear_errors_i) begin
            error_o <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk_usb_buf) begin
      if (push) begin
         mem[wr_ptr_q] <= push_data;
      end
      if (pop_i) begin
         rdata_o <= pop_ok ? mem[rd_ptr_q] : '0;
      end
   end

   // a full buffer must not move the write pointer onto the oldest sample
   a_no_push_full: assert property (@(posedge clk_usb_buf) disable iff (!rst_n_i)
      full_o && !flush_i |=> wr_ptr_q == $past(wr_ptr_q));

   a_count_bound: assert property (@(posedge clk_usb_buf) disable iff (!rst_n_i)
      count_q <= capture_pkg::CNT_W'(capture_pkg::FIFO_DEPTH));

endmodule

// ==== verilog/error_led_timer.sv ====
`timescale 1ns/10ps

module error_led_timer (
   input  logic clk_usb_buf,
   input  logic rst_n_i,
   input  logic error_i,
   output logic led_error_o
);

   logic [capture_pkg::FLASH_W-1:0] flash_cnt_q;

   always_ff @(posedge clk_usb_buf or negedge rst_n_i) begin
      if (!rst_n_i) begin
         flash_cnt_q <= '0;
         led_error_o <= 1'b0;
      end else begin
         flash_cnt_q <= flash_cnt_q + 1'b1;   // free running
         led_error_o <= error_i & flash_cnt_q[capture_pkg::FLASH_W-1];
      end
   end

endmodule

// ==== verilog/capture_top.sv ====
`timescale 1ns/10ps

module capture_top (
   input  logic                            clk_usb_buf,
   input  logic                            rst_n_i,
   input  logic                            usb_cen_n_i,
   input  logic                            usb_wrn_n_i,
   input  logic                            usb_rdn_n_i,
   input  logic [capture_pkg::ADDR_W-1:0]  usb_addr_i,
   input  logic [capture_pkg::DATA_W-1:0]  usb_data_i,
   output logic [capture_pkg::DATA_W-1:0]  usb_data_o,
   output logic                            usb_data_oe_o,
   input  logic                            trace_valid_i,
   input  logic [capture_pkg::DATA_W-1:0]  trace_data_i,
   output logic                            trace_ready_o,
   input  logic                            la_valid_i,
   input  logic [capture_pkg::DATA_W-1:0]  la_data_i,
   output logic                            la_ready_o,
   output logic                            led_armed_o,
   output logic                            led_error_o
);

   logic [capture_pkg::ADDR_W-1:0] reg_address;
   logic [capture_pkg::DATA_W-1:0] write_data;
   logic [capture_pkg::DATA_W-1:0] reg_rdata;
   logic                           reg_write;
   logic                           reg_read;

   logic                           arm;
   logic                           src_la;
   logic                           fifo_pop;
   logic                           fifo_flush;
   logic                           clear_errors;
   logic [capture_pkg::DATA_W-1:0] fifo_rdata;
   logic [capture_pkg::CNT_W-1:0]  fifo_count;
   logic                           fifo_empty;
   logic                           fifo_full;
   logic                           fifo_error;

   usb_reg_bus u_usb_reg_bus (
      .clk_usb_buf   (clk_usb_buf),
      .rst_n_i       (rst_n_i),
      .usb_cen_n_i   (usb_cen_n_i),
      .usb_wrn_n_i   (usb_wrn_n_i),
      .usb_rdn_n_i   (usb_rdn_n_i),
      .usb_addr_i    (usb_addr_i),
      .usb_data_i    (usb_data_i),
      .usb_data_o    (usb_data_o),
      .usb_data_oe_o (usb_data_oe_o),
      .reg_address_o (reg_address),
      .write_data_o  (write_data),
      .reg_write_o   (reg_write),
      .reg_read_o    (reg_read),
      .reg_rdata_i   (reg_rdata)
   );

   capture_regs u_capture_regs (
      .clk_usb_buf    (clk_usb_buf),
      .rst_n_i        (rst_n_i),
      .reg_address_i  (reg_address),
      .write_data_i   (write_data),
      .reg_write_i    (reg_write),
      .reg_read_i     (reg_read),
      .reg_rdata_o    (reg_rdata),
      .arm_o          (arm),
      .src_la_o       (src_la),
      .fifo_pop_o     (fifo_pop),
      .fifo_flush_o   (fifo_flush),
      .clear_errors_o (clear_errors),
      .fifo_rdata_i   (fifo_rdata),
      .fifo_count_i   (fifo_count),
      .fifo_empty_i   (fifo_empty),
      .fifo_full_i    (fifo_full),
      .fifo_error_i   (fifo_error)
   );

   capture_fifo u_capture_fifo (
      .clk_usb_buf    (clk_usb_buf),
      .rst_n_i        (rst_n_i),
      .arm_i          (arm),
      .src_la_i       (src_la),
      .trace_valid_i  (trace_valid_i),
      .trace_data_i   (trace_data_i),
      .trace_ready_o  (trace_ready_o),
      .la_valid_i     (la_valid_i),
      .la_data_i      (la_data_i),
      .la_ready_o     (la_ready_o),
      .pop_i          (fifo_pop),
      .flush_i        (fifo_flush),
      .clear_errors_i (clear_errors),
      .rdata_o        (fifo_rdata),
      .count_o        (fifo_count),
      .empty_o        (fifo_empty),
      .full_o         (fifo_full),
      .error_o        (fifo_error)
   );

   error_led_timer u_error_led_timer (
      .clk_usb_buf (clk_usb_buf),
      .rst_n_i     (rst_n_i),
      .error_i     (fifo_error),
      .led_error_o (led_error_o)
   );

   assign led_armed_o = arm;   // lit while capture is armed

endmodule

// ==== tests/tb_capture_top.sv ====
`timescale 1ns/10ps

module tb_capture_top;

   logic       clk_usb_buf;
   logic       rst_n_i;
   logic       usb_cen_n_i;
   logic       usb_wrn_n_i;
   logic       usb_rdn_n_i;
   logic [7:0] usb_addr_i;
   logic [7:0] usb_data_i;
   logic [7:0] usb_data_o;
   logic       usb_data_oe_o;
   logic       trace_valid_i;
   logic [7:0] trace_data_i;
   logic       trace_ready_o;
   logic       la_valid_i;
   logic [7:0] la_data_i;
   logic       la_ready_o;
   logic       led_armed_o;
   logic       led_error_o;

   logic [31:0] lfsr_q;
   logic [7:0]  exp_q[$];   // samples in the order they entered the buffer
   int          cycle_cnt;
   int          err_cnt;

   capture_top dut (.*);

   initial begin
      clk_usb_buf = 1'b0;
      forever #20 clk_usb_buf = ~clk_usb_buf;
   end

   // tests need a few hundred cycles, so 4000 leaves a wide margin
   initial begin
      cycle_cnt = 0;
      while (cycle_cnt < 4000) begin
         @(posedge clk_usb_buf);
         cycle_cnt++;
      end
      $display("Simulation ran past 4000 cycles without finishing the tests");
      fail_run();
   end

   task automatic fail_run();
      $display("Test failures found");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] exp);
      assert (got === exp) else begin
         err_cnt++;
         $display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
         fail_run();
      end
   endtask

   task automatic check_cond(input bit cond, input string what);
      assert (cond) else begin
         err_cnt++;
         $display("At %0t: %s", $time, what);
         fail_run();
      end
   endtask

   // taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      lfsr_step = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic next_byte(output logic [7:0] b);
      b = '0;
      repeat (8) begin
         lfsr_q = lfsr_step(lfsr_q);
         b = {b[6:0], lfsr_q[0]};   // one step per bit
      end
   endtask

   function automatic logic [7:0] status_word(input bit err, input bit full, input bit empty,
                                              input int count);
      status_word = {err, full, empty, 5'(count)};
   endfunction

   task automatic bus_write(input logic [7:0] addr, input logic [7:0] data);
      @(negedge clk_usb_buf);
      usb_addr_i  = addr;
      usb_data_i  = data;
      usb_cen_n_i = 1'b0;
      usb_wrn_n_i = 1'b0;
      repeat (2) @(negedge clk_usb_buf);
      usb_wrn_n_i = 1'b1;
      usb_cen_n_i = 1'b1;
      @(negedge clk_usb_buf);   // bus fsm back in idle
   endtask

   task automatic bus_read(input logic [7:0] addr, output logic [7:0] data);
      @(negedge clk_usb_buf);
      usb_addr_i  = addr;
      usb_cen_n_i = 1'b0;
      usb_rdn_n_i = 1'b0;
      repeat (3) @(negedge clk_usb_buf);   // data driven from cycle 2
      check_cond(usb_data_oe_o === 1'b1, "usb_data_oe_o was low when read data was sampled");
      data        = usb_data_o;
      usb_rdn_n_i = 1'b1;
      usb_cen_n_i = 1'b1;
      @(negedge clk_usb_buf);
      check_cond(usb_data_oe_o === 1'b0, "usb_data_oe_o stayed high after the read strobe");
   endtask

   task automatic read_expect(input logic [7:0] addr, input logic [7:0] exp, input string name);
      logic [7:0] got;
      bus_read(addr, got);
      check_value(name, got, exp);
   endtask

   task automatic offer_trace(input logic [7:0] b);
      @(negedge clk_usb_buf);
      trace_valid_i = 1'b1;
      trace_data_i  = b;
      while (trace_ready_o !== 1'b1) @(negedge clk_usb_buf);   // hold data under back-pressure
      check_value("la_ready_o", la_ready_o, 1'b0);
      exp_q.push_back(b);
      @(negedge clk_usb_buf);   // taken at the edge in between
      trace_valid_i = 1'b0;
   endtask

   task automatic drain_and_check(input int n);
      for (int i = 0; i < n; i++) begin
         read_expect(capture_pkg::REG_FIFO_DATA, exp_q.pop_front(), "FIFO_DATA");
      end
   endtask

   task automatic led_activity(output bit saw_hi, output bit saw_lo);
      saw_hi = 1'b0;
      saw_lo = 1'b0;
      repeat (16) begin
         @(negedge clk_usb_buf);
         if (led_error_o) saw_hi = 1'b1;
         else saw_lo = 1'b1;
      end
   endtask

   task automatic test_id_and_unused();
      read_expect(capture_pkg::REG_ID, 8'hC7, "REG_ID");
      read_expect(8'h55, 8'h00, "unused address 0x55");
   endtask

   task automatic test_ctrl_readback();
      bus_write(capture_pkg::REG_CTRL, 8'h01);
      read_expect(capture_pkg::REG_CTRL, 8'h01, "REG_CTRL");
      check_value("led_armed_o", led_armed_o, 1'b1);
      bus_write(capture_pkg::REG_CTRL, 8'h02);
      read_expect(capture_pkg::REG_CTRL, 8'h02, "REG_CTRL");
      check_value("led_armed_o", led_armed_o, 1'b0);
      bus_write(capture_pkg::REG_CTRL, 8'h00);
   endtask

   task automatic test_trace_capture();
      logic [7:0] b;
      bus_write(capture_pkg::REG_CTRL, 8'h01);   // arm, trace source
      for (int i = 0; i < 6; i++) begin
         next_byte(b);
         offer_trace(b);
      end
      read_expect(capture_pkg::REG_STATUS, status_word(0, 0, 0, 6), "REG_STATUS");
      drain_and_check(6);
      bus_write(capture_pkg::REG_CTRL, 8'h00);
   endtask

   task automatic test_la_fill();
      logic [7:0] b;
      int         accepted;
      bit         holding;
      accepted = 0;
      holding  = 1'b0;
      bus_write(capture_pkg::REG_CTRL, 8'h03);   // arm, logic analyzer source
      for (int i = 0; i < 16 + 3; i++) begin
         @(negedge clk_usb_buf);
         if (!holding) begin
            next_byte(b);
            la_data_i = b;
         end
         la_valid_i = 1'b1;
         check_value("la_ready_o", la_ready_o, accepted < 16);
         check_value("trace_ready_o", trace_ready_o, 1'b0);
         if (accepted < 16) begin   // room left in the buffer
            exp_q.push_back(la_data_i);
            accepted++;
            holding = 1'b0;
         end else begin
            holding = 1'b1;
         end
      end
      @(negedge clk_usb_buf);
      la_valid_i = 1'b0;
      read_expect(capture_pkg::REG_STATUS, status_word(0, 1, 0, 16), "REG_STATUS");
      drain_and_check(16);
      bus_write(capture_pkg::REG_CTRL, 8'h00);
   endtask

   task automatic test_underflow_error();
      bit hi;
      bit lo;
      read_expect(capture_pkg::REG_FIFO_DATA, 8'h00, "FIFO_DATA on empty buffer");
      read_expect(capture_pkg::REG_STATUS, status_word(1, 0, 1, 0), "REG_STATUS");
      led_activity(hi, lo);
      check_cond(hi && lo, "led_error_o did not flash while the error was pending");
      bus_write(capture_pkg::REG_CLEAR, 8'h02);
      read_expect(capture_pkg::REG_STATUS, status_word(0, 0, 1, 0), "REG_STATUS");
      led_activity(hi, lo);
      check_cond(!hi, "led_error_o went high after the error was cleared");
   endtask

   task automatic test_flush();
      logic [7:0] b;
      bus_write(capture_pkg::REG_CTRL, 8'h01);
      for (int i = 0; i < 5; i++) begin
         next_byte(b);
         offer_trace(b);
      end
      read_expect(capture_pkg::REG_STATUS, status_word(0, 0, 0, 5), "REG_STATUS");
      bus_write(capture_pkg::REG_CLEAR, 8'h01);
      exp_q.delete();
      read_expect(capture_pkg::REG_STATUS, status_word(0, 0, 1, 0), "REG_STATUS");
      bus_write(capture_pkg::REG_CTRL, 8'h00);
   endtask

   initial begin
      err_cnt       = 0;
      lfsr_q        = 32'h3af5_dad2;
      rst_n_i       = 1'b0;
      usb_cen_n_i   = 1'b1;
      usb_wrn_n_i   = 1'b1;
      usb_rdn_n_i   = 1'b1;
      usb_addr_i    = '0;
      usb_data_i    = '0;
      trace_valid_i = 1'b0;
      trace_data_i  = '0;
      la_valid_i    = 1'b0;
      la_data_i     = '0;
      repeat (16) @(negedge clk_usb_buf);
      rst_n_i = 1'b1;
      @(negedge clk_usb_buf);
      check_value("led_armed_o", led_armed_o, 1'b0);
      check_value("led_error_o", led_error_o, 1'b0);
      check_value("trace_ready_o", trace_ready_o, 1'b0);
      check_value("la_ready_o", la_ready_o, 1'b0);
      check_value("usb_data_oe_o", usb_data_oe_o, 1'b0);
      test_id_and_unused();
      test_ctrl_readback();
      test_trace_capture();
      test_la_fill();
      test_underflow_error();
      test_flush();
      if (err_cnt == 0) begin
         $display("All tests passed!");
         $finish;
      end else begin
         fail_run();
      end
   end

endmodule

// ==== list.f ====
verilog/capture_pkg.sv
verilog/usb_reg_bus.sv
verilog/capture_regs.sv
verilog/capture_fifo.sv
verilog/error_led_timer.sv
verilog/capture_top.sv
tests/tb_capture_top.sv
